/* source/vpu_pkg.sv */
// Shared widths, vector types and function codes for the vector group slice.
// Integer only: no rounding mode, no operand type tags, no third source.
// Group selects are one-hot; only the two low bits name groups that exist.
// VLEN must stay a whole number of lanes.

package vpu_pkg;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int LANE_W    = 16;
  localparam int NUM_LANES = 4;
  localparam int VLEN      = NUM_LANES * LANE_W;
  localparam int GP_WIDTH  = 4;
  localparam int ID_W      = 2;
  localparam int FUNC_W    = 3;

  // ======================================================================
  // Types
  // ======================================================================
  typedef logic [VLEN-1:0]     vreg_t;
  typedef logic [LANE_W-1:0]   lane_t;
  typedef logic [GP_WIDTH-1:0] gp_sel_t;
  typedef logic [ID_W-1:0]     id_t;

  // Integer lane functions
  typedef enum logic [FUNC_W-1:0] {
    FN_ADD   = 3'd0,
    FN_SUB   = 3'd1,
    FN_AND   = 3'd2,
    FN_OR    = 3'd3,
    FN_XOR   = 3'd4,
    FN_MINU  = 3'd5,
    FN_MAXU  = 3'd6,
    FN_SADDU = 3'd7
  } vpu_func_e;

  // ======================================================================
  // Group indices
  // ======================================================================
  localparam gp_sel_t GROUP0_INDEX = 4'b0001;
  localparam gp_sel_t GROUP1_INDEX = 4'b0010;

  // Bits of the group select that map to a real group
  localparam gp_sel_t GROUP_USED_MASK = GROUP0_INDEX | GROUP1_INDEX;

endpackage

/* source/vpu_lane_alu.sv */
// Four-lane 16-bit integer ALU, purely combinational.
// Each lane is computed on its own; carries and borrows stay in the lane.
// Min and max compare unsigned. FN_SADDU clamps an overflowing lane to
// all ones; FN_ADD and FN_SUB wrap.

`timescale 1ns/1ps

module vpu_lane_alu
  import vpu_pkg::*;
(
  input  vpu_func_e func,
  input  vreg_t     srcv0,
  input  vreg_t     srcv1,
  output vreg_t     result
);

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_t           a;
    lane_t           b;
    lane_t           lane_res;
    logic [LANE_W:0] sum;
    logic            a_lt_b;

    assign a = srcv0[g*LANE_W +: LANE_W];
    assign b = srcv1[g*LANE_W +: LANE_W];

    // Extra bit catches the lane carry out for saturation
    assign sum    = {1'b0, a} + {1'b0, b};
    assign a_lt_b = (a < b);

    always_comb begin
      case (func)
        FN_ADD: begin
          lane_res = sum[LANE_W-1:0];
        end
        FN_SUB: begin
          lane_res = a - b;
        end
        FN_AND: begin
          lane_res = a & b;
        end
        FN_OR: begin
          lane_res = a | b;
        end
        FN_XOR: begin
          lane_res = a ^ b;
        end
        FN_MINU: begin
          lane_res = a_lt_b ? a : b;
        end
        FN_MAXU: begin
          lane_res = a_lt_b ? b : a;
        end
        FN_SADDU: begin
          lane_res = sum[LANE_W] ? '1 : sum[LANE_W-1:0];
        end
        default: begin
          lane_res = '0;
        end
      endcase
    end

    assign result[g*LANE_W +: LANE_W] = lane_res;
  end

endmodule

/* source/vpu_issue_pipe.sv */
// Issue handshake and ex1..ex4 control pipeline.
// One operation accepted per cycle when in_valid and in_ready are both high.
// in_ready is simply ~stall; a stall freezes every stage, valid bits included.
// Operands live in ex1 only; func and group select travel to ex4.
// The tag rides along internally and leaves only at ex4.

`timescale 1ns/1ps

module vpu_issue_pipe
  import vpu_pkg::*;
(
  input  logic      cpuclk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  vpu_func_e in_func,
  input  gp_sel_t   in_gp_sel,
  input  id_t       in_id,
  input  vreg_t     in_srcv0,
  input  vreg_t     in_srcv1,
  input  logic      stall,
  output logic      in_ready,
  output logic      ex1_valid,
  output logic      ex2_valid,
  output logic      ex3_valid,
  output logic      ex4_valid,
  output vpu_func_e ex1_func,
  output vpu_func_e ex2_func,
  output vpu_func_e ex3_func,
  output vpu_func_e ex4_func,
  output gp_sel_t   ex1_gp_sel,
  output gp_sel_t   ex2_gp_sel,
  output gp_sel_t   ex3_gp_sel,
  output gp_sel_t   ex4_gp_sel,
  output vreg_t     ex1_srcv0,
  output vreg_t     ex1_srcv1,
  output id_t       ex4_id
);

  id_t ex1_id;
  id_t ex2_id;
  id_t ex3_id;

  assign in_ready = ~stall;

  // ======================================================================
  // Stage valid chain
  // ======================================================================
  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      ex1_valid <= 1'b0;
      ex2_valid <= 1'b0;
      ex3_valid <= 1'b0;
      ex4_valid <= 1'b0;
    end else if (!stall) begin
      // An empty issue slot becomes a bubble in ex1
      ex1_valid <= in_valid;
      ex2_valid <= ex1_valid;
      ex3_valid <= ex2_valid;
      ex4_valid <= ex3_valid;
    end
  end

  // ======================================================================
  // Stage payload
  // ======================================================================
  // ex1 loads only on an accepted operation
  always_ff @(posedge cpuclk) begin
    if (!stall && in_valid) begin
      ex1_func   <= in_func;
      ex1_gp_sel <= in_gp_sel;
      ex1_id     <= in_id;
      ex1_srcv0  <= in_srcv0;
      ex1_srcv1  <= in_srcv1;
    end
  end

  // Control shifts down with the valid bits
  always_ff @(posedge cpuclk) begin
    if (!stall) begin
      ex2_func   <= ex1_func;
      ex2_gp_sel <= ex1_gp_sel;
      ex2_id     <= ex1_id;
      ex3_func   <= ex2_func;
      ex3_gp_sel <= ex2_gp_sel;
      ex3_id     <= ex2_id;
      ex4_func   <= ex3_func;
      ex4_gp_sel <= ex3_gp_sel;
      ex4_id     <= ex3_id;
    end
  end

  // Every issued op must name exactly one existing group
  a_gp_sel_legal : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
    in_valid |-> ($onehot(in_gp_sel) && ((in_gp_sel & ~GROUP_USED_MASK) == '0))
  );

endmodule

/* source/vpu_group_unit.sv */
// One execution group: stage ownership decode plus its result pipeline.
// GROUP_INDEX is the one-hot group this instance answers to.
// The ALU runs in ex1; results move ex2 -> ex3 -> ex4 only on owned stages,
// so a group's registers keep their contents while the other group works.
// All result registers hold while stall is high.

`timescale 1ns/1ps

module vpu_group_unit
  import vpu_pkg::*;
#(
  parameter gp_sel_t GROUP_INDEX = GROUP0_INDEX
) (
  input  logic      cpuclk,
  input  logic      arst_n,
  input  logic      stall,
  input  logic      ex1_valid,
  input  logic      ex2_valid,
  input  logic      ex3_valid,
  input  logic      ex4_valid,
  input  vpu_func_e ex1_func,
  input  gp_sel_t   ex1_gp_sel,
  input  gp_sel_t   ex2_gp_sel,
  input  gp_sel_t   ex3_gp_sel,
  input  gp_sel_t   ex4_gp_sel,
  input  vreg_t     ex1_srcv0,
  input  vreg_t     ex1_srcv1,
  output logic      ex1_sel,
  output logic      ex2_sel,
  output logic      ex3_sel,
  output logic      ex4_sel,
  output vreg_t     ex4_result
);

  vreg_t alu_srcv0;
  vreg_t alu_srcv1;
  vreg_t alu_result;
  vreg_t ex2_result;
  vreg_t ex3_result;

  // Stage belongs to this group when valid and the select bit matches
  function automatic logic stage_owned(input logic valid, input gp_sel_t gp_sel);
    return valid & (|(gp_sel & GROUP_INDEX));
  endfunction

  // ======================================================================
  // Stage ownership
  // ======================================================================
  assign ex1_sel = stage_owned(ex1_valid, ex1_gp_sel);
  assign ex2_sel = stage_owned(ex2_valid, ex2_gp_sel);
  assign ex3_sel = stage_owned(ex3_valid, ex3_gp_sel);
  assign ex4_sel = stage_owned(ex4_valid, ex4_gp_sel);

  // Keep the ALU quiet when ex1 is not ours
  assign alu_srcv0 = ex1_sel ? ex1_srcv0 : '0;
  assign alu_srcv1 = ex1_sel ? ex1_srcv1 : '0;

  vpu_lane_alu u_lane_alu (
    .func   (ex1_func),
    .srcv0  (alu_srcv0),
    .srcv1  (alu_srcv1),
    .result (alu_result)
  );

  // ======================================================================
  // Result pipeline
  // ======================================================================
  always_ff @(posedge cpuclk) begin
    if (!stall) begin
      if (ex1_sel) begin
        ex2_result <= alu_result;
      end
      if (ex2_sel) begin
        ex3_result <= ex2_result;
      end
      if (ex3_sel) begin
        ex4_result <= ex3_result;
      end
    end
  end

  // An owned ex4 must have been filled all the way from ex1
  a_ex4_result_loaded : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
    ex4_sel |-> !$isunknown(ex4_result)
  );

endmodule

/* source/vpu_retire.sv */
// Retire stage: picks the ex4 result of the owning group.
// out_valid follows ex4_valid; stall holds the whole pipe while the
// consumer is not ready, which keeps out_data and out_id stable.
// Combinational from ex4; the clock and reset only serve the checks.

`timescale 1ns/1ps

module vpu_retire
  import vpu_pkg::*;
(
  input  logic  cpuclk,
  input  logic  arst_n,
  input  logic  ex4_valid,
  input  id_t   ex4_id,
  input  logic  ex4_sel_g0,
  input  logic  ex4_sel_g1,
  input  vreg_t ex4_result_g0,
  input  vreg_t ex4_result_g1,
  input  logic  out_ready,
  output logic  out_valid,
  output vreg_t out_data,
  output id_t   out_id,
  output logic  stall
);

  // ======================================================================
  // Output select and handshake
  // ======================================================================
  // Owners are one-hot, so an AND-OR mux is enough
  assign out_data = ({VLEN{ex4_sel_g0}} & ex4_result_g0)
                  | ({VLEN{ex4_sel_g1}} & ex4_result_g1);

  assign out_valid = ex4_valid;
  assign out_id    = ex4_id;

  // Back-pressure with a live ex4 freezes everything upstream
  assign stall = ex4_valid & ~out_ready;

  // ======================================================================
  // Checks
  // ======================================================================
  a_one_owner : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
    ex4_valid |-> $onehot({ex4_sel_g1, ex4_sel_g0})
  );

  // Pending result holds until it is taken
  a_out_hold : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_id))
  );

endmodule

/* source/vpu_group_top.sv */
// Vector group slice top: issue pipe, two group units, retire.
// Group 0 answers to select 0001, group 1 to 0010.
// Results leave in issue order, four ex stages after acceptance.

`timescale 1ns/1ps

module vpu_group_top
  import vpu_pkg::*;
(
  input  logic      cpuclk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  vpu_func_e in_func,
  input  gp_sel_t   in_gp_sel,
  input  id_t       in_id,
  input  vreg_t     in_srcv0,
  input  vreg_t     in_srcv1,
  output logic      in_ready,
  output logic      out_valid,
  output vreg_t     out_data,
  output id_t       out_id,
  input  logic      out_ready
);

  logic      stall;
  logic      ex1_valid;
  logic      ex2_valid;
  logic      ex3_valid;
  logic      ex4_valid;
  vpu_func_e ex1_func;
  gp_sel_t   ex1_gp_sel;
  gp_sel_t   ex2_gp_sel;
  gp_sel_t   ex3_gp_sel;
  gp_sel_t   ex4_gp_sel;
  vreg_t     ex1_srcv0;
  vreg_t     ex1_srcv1;
  id_t       ex4_id;
  logic      ex4_sel_g0;
  logic      ex4_sel_g1;
  vreg_t     ex4_result_g0;
  vreg_t     ex4_result_g1;

  vpu_issue_pipe u_issue_pipe (
    .cpuclk     (cpuclk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_func    (in_func),
    .in_gp_sel  (in_gp_sel),
    .in_id      (in_id),
    .in_srcv0   (in_srcv0),
    .in_srcv1   (in_srcv1),
    .stall      (stall),
    .in_ready   (in_ready),
    .ex1_valid  (ex1_valid),
    .ex2_valid  (ex2_valid),
    .ex3_valid  (ex3_valid),
    .ex4_valid  (ex4_valid),
    .ex1_func   (ex1_func),
    .ex2_func   (),
    .ex3_func   (),
    .ex4_func   (),
    .ex1_gp_sel (ex1_gp_sel),
    .ex2_gp_sel (ex2_gp_sel),
    .ex3_gp_sel (ex3_gp_sel),
    .ex4_gp_sel (ex4_gp_sel),
    .ex1_srcv0  (ex1_srcv0),
    .ex1_srcv1  (ex1_srcv1),
    .ex4_id     (ex4_id)
  );

  vpu_group_unit #(
    .GROUP_INDEX (GROUP0_INDEX)
  ) u_group0 (
    .cpuclk     (cpuclk),
    .arst_n     (arst_n),
    .stall      (stall),
    .ex1_valid  (ex1_valid),
    .ex2_valid  (ex2_valid),
    .ex3_valid  (ex3_valid),
    .ex4_valid  (ex4_valid),
    .ex1_func   (ex1_func),
    .ex1_gp_sel (ex1_gp_sel),
    .ex2_gp_sel (ex2_gp_sel),
    .ex3_gp_sel (ex3_gp_sel),
    .ex4_gp_sel (ex4_gp_sel),
    .ex1_srcv0  (ex1_srcv0),
    .ex1_srcv1  (ex1_srcv1),
    .ex1_sel    (),
    .ex2_sel    (),
    .ex3_sel    (),
    .ex4_sel    (ex4_sel_g0),
    .ex4_result (ex4_result_g0)
  );

  vpu_group_unit #(
    .GROUP_INDEX (GROUP1_INDEX)
  ) u_group1 (
    .cpuclk     (cpuclk),
    .arst_n     (arst_n),
    .stall      (stall),
    .ex1_valid  (ex1_valid),
    .ex2_valid  (ex2_valid),
    .ex3_valid  (ex3_valid),
    .ex4_valid  (ex4_valid),
    .ex1_func   (ex1_func),
    .ex1_gp_sel (ex1_gp_sel),
    .ex2_gp_sel (ex2_gp_sel),
    .ex3_gp_sel (ex3_gp_sel),
    .ex4_gp_sel (ex4_gp_sel),
    .ex1_srcv0  (ex1_srcv0),
    .ex1_srcv1  (ex1_srcv1),
    .ex1_sel    (),
    .ex2_sel    (),
    .ex3_sel    (),
    .ex4_sel    (ex4_sel_g1),
    .ex4_result (ex4_result_g1)
  );

  vpu_retire u_retire (
    .cpuclk        (cpuclk),
    .arst_n        (arst_n),
    .ex4_valid     (ex4_valid),
    .ex4_id        (ex4_id),
    .ex4_sel_g0    (ex4_sel_g0),
    .ex4_sel_g1    (ex4_sel_g1),
    .ex4_result_g0 (ex4_result_g0),
    .ex4_result_g1 (ex4_result_g1),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_id        (out_id),
    .stall         (stall)
  );

endmodule

/* tb/vpu_group_tb.sv */
// Testbench for the vector group slice top level.
// Stimulus comes from a fixed table, applied once after reset.
// Inputs change on the falling clock edge; outputs are sampled 1 ns later.
// Expected results come from a lane model in this file, checked in issue order.
// Random gaps and back-pressure use a 16-bit LFSR with seed 13.
// The first error stops the run.

`timescale 1ns/1ps

module vpu_group_tb
  import vpu_pkg::*;
();

  localparam int NUM_ENTRIES     = 24;
  localparam int STREAM_TIMEOUT  = 400;
  localparam int LATENCY_TIMEOUT = 10;

  logic      cpuclk;
  logic      arst_n;
  logic      in_valid;
  vpu_func_e in_func;
  gp_sel_t   in_gp_sel;
  id_t       in_id;
  vreg_t     in_srcv0;
  vreg_t     in_srcv1;
  logic      in_ready;
  logic      out_valid;
  vreg_t     out_data;
  id_t       out_id;
  logic      out_ready;

  // Stimulus table
  vpu_func_e tbl_func [NUM_ENTRIES];
  gp_sel_t   tbl_gp   [NUM_ENTRIES];
  vreg_t     tbl_a    [NUM_ENTRIES];
  vreg_t     tbl_b    [NUM_ENTRIES];
  id_t       tbl_id   [NUM_ENTRIES];

  // Scoreboard, oldest operation at the head
  vreg_t exp_data_q [$];
  id_t   exp_id_q   [$];

  logic [15:0] lfsr_state;

  vpu_group_top dut (
    .cpuclk    (cpuclk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_func   (in_func),
    .in_gp_sel (in_gp_sel),
    .in_id     (in_id),
    .in_srcv0  (in_srcv0),
    .in_srcv1  (in_srcv1),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_id    (out_id),
    .out_ready (out_ready)
  );

  initial begin
    cpuclk = 1'b0;
    forever #2 cpuclk = ~cpuclk;
  end

  // ======================================================================
  // Error reporting
  // ======================================================================
  task automatic end_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at t=%0t: %s", $time, what);
    end_with_failure();
  endtask

  // ======================================================================
  // Random bits and reference model
  // ======================================================================
  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[15];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  // Lane rules worked in integer arithmetic, one lane at a time
  function automatic vreg_t model_result(input vpu_func_e fn, input vreg_t a, input vreg_t b);
    vreg_t       r;
    int unsigned x;
    int unsigned y;
    int unsigned z;
    int unsigned lane_mod;
    lane_mod = 1 << LANE_W;
    r = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      x = a[l*LANE_W +: LANE_W];
      y = b[l*LANE_W +: LANE_W];
      case (fn)
        FN_ADD:   z = (x + y) % lane_mod;
        FN_SUB:   z = (x + lane_mod - y) % lane_mod;
        FN_AND:   z = x & y;
        FN_OR:    z = x | y;
        FN_XOR:   z = x ^ y;
        FN_MINU:  z = (x <= y) ? x : y;
        FN_MAXU:  z = (x >= y) ? x : y;
        FN_SADDU: z = (x + y >= lane_mod) ? lane_mod - 1 : x + y;
        default:  z = 0;
      endcase
      r[l*LANE_W +: LANE_W] = z[LANE_W-1:0];
    end
    return r;
  endfunction

  // ======================================================================
  // Table
  // ======================================================================
  task automatic add_entry(input int idx, input vpu_func_e fn, input int grp,
                           input vreg_t a, input vreg_t b, input id_t tag);
    tbl_func[idx] = fn;
    tbl_gp[idx]   = (grp == 1) ? GROUP1_INDEX : GROUP0_INDEX;
    tbl_a[idx]    = a;
    tbl_b[idx]    = b;
    tbl_id[idx]   = tag;
  endtask

  task automatic load_table();
    // Lone op for the latency check
    add_entry(0,  FN_ADD,   0, 64'h0001_0002_0003_0004, 64'h0010_0020_0030_0040, 2'd0);
    // Back to back, groups alternate; lane carries and borrows
    add_entry(1,  FN_ADD,   1, 64'hFFFF_0001_8000_7FFF, 64'h0001_FFFF_8000_0001, 2'd1);
    add_entry(2,  FN_SUB,   0, 64'h0000_0005_1234_8000, 64'h0001_0003_1234_0001, 2'd2);
    add_entry(3,  FN_SUB,   1, 64'h0001_0000_FFFF_0000, 64'h0002_FFFF_0001_0001, 2'd3);
    add_entry(4,  FN_AND,   0, 64'hF0F0_FFFF_1234_AAAA, 64'h0FF0_0000_FFFF_5555, 2'd0);
    add_entry(5,  FN_OR,    1, 64'hF0F0_0000_1234_AAAA, 64'h0F0F_0000_4321_5555, 2'd1);
    add_entry(6,  FN_XOR,   0, 64'hFFFF_1234_AAAA_0000, 64'h0F0F_1234_5555_FFFF, 2'd2);
    // Unsigned min and max: equal, low, high, top bit set
    add_entry(7,  FN_MINU,  1, 64'h1234_0001_FFFF_8000, 64'h1234_FFFF_0001_7FFF, 2'd3);
    add_entry(8,  FN_MAXU,  0, 64'h1234_0001_FFFF_8000, 64'h1234_FFFF_0001_7FFF, 2'd0);
    // Saturating adds, with and without overflow
    add_entry(9,  FN_SADDU, 1, 64'hFFFF_8000_7FFF_0001, 64'h0001_8000_8000_0002, 2'd1);
    add_entry(10, FN_SADDU, 0, 64'h0000_1000_FFFE_C000, 64'h0000_2000_0001_4000, 2'd2);
    add_entry(11, FN_ADD,   1, 64'h00FF_FF00_FFFF_0FFF, 64'h0001_0100_0002_F001, 2'd3);
    // Random gaps and back-pressure
    add_entry(12, FN_XOR,   1, 64'hFFFF_0000_A5A5_1234, 64'hFFFF_FFFF_5A5A_4321, 2'd0);
    add_entry(13, FN_OR,    0, 64'h8000_0001_00F0_0F00, 64'h0001_8000_0F00_00F0, 2'd1);
    add_entry(14, FN_MINU,  0, 64'h0000_FFFF_7FFF_8001, 64'hFFFF_0000_8000_8001, 2'd2);
    add_entry(15, FN_MAXU,  1, 64'h0000_FFFF_7FFF_8001, 64'hFFFF_0000_8000_8001, 2'd3);
    add_entry(16, FN_SADDU, 0, 64'hFFFF_FFFF_0000_8001, 64'hFFFF_0000_0000_7FFF, 2'd0);
    add_entry(17, FN_SUB,   1, 64'h0000_0000_0000_0000, 64'h0001_0001_0001_0001, 2'd1);
    add_entry(18, FN_ADD,   0, 64'h7FFF_7FFF_FFFF_0000, 64'h0001_8001_FFFF_0000, 2'd2);
    add_entry(19, FN_AND,   1, 64'hFFFF_0000_5A5A_C3C3, 64'h1234_FFFF_FFFF_3C3C, 2'd3);
    add_entry(20, FN_SADDU, 1, 64'h1234_0FFF_F000_0001, 64'h4321_F000_0FFF_FFFE, 2'd0);
    add_entry(21, FN_MINU,  0, 64'h8000_0002_0003_CAFE, 64'h7FFF_0003_0002_CAFE, 2'd1);
    add_entry(22, FN_MAXU,  1, 64'h8000_0002_0003_CAFE, 64'h7FFF_0003_0002_CAFE, 2'd2);
    add_entry(23, FN_SUB,   0, 64'h8000_0000_FFFF_1000, 64'h0001_8000_FFFF_2000, 2'd3);
  endtask

  // ======================================================================
  // Driving and checking
  // ======================================================================
  task automatic drive_entry(input int idx);
    in_func   = tbl_func[idx];
    in_gp_sel = tbl_gp[idx];
    in_id     = tbl_id[idx];
    in_srcv0  = tbl_a[idx];
    in_srcv1  = tbl_b[idx];
  endtask

  task automatic push_expected(input int idx);
    exp_data_q.push_back(model_result(tbl_func[idx], tbl_a[idx], tbl_b[idx]));
    exp_id_q.push_back(tbl_id[idx]);
  endtask

  // Called when a transfer will happen at the next rising edge
  task automatic check_output();
    assert (exp_data_q.size() > 0)
      else report_failure("output transfer with no operation outstanding");
    assert (out_data === exp_data_q[0])
      else report_mismatch("out_data", exp_data_q[0], out_data);
    assert (out_id === exp_id_q[0])
      else report_mismatch("out_id", exp_id_q[0], out_id);
    void'(exp_data_q.pop_front());
    void'(exp_id_q.pop_front());
  endtask

  task automatic check_reset_and_latency(input int idx);
    int edges;
    @(negedge cpuclk);
    out_ready = 1'b1;
    drive_entry(idx);
    in_valid = 1'b1;
    #1;
    assert (out_valid === 1'b0) else report_mismatch("out_valid", 1'b0, out_valid);
    assert (in_ready === 1'b1) else report_mismatch("in_ready", 1'b1, in_ready);
    push_expected(idx);
    @(negedge cpuclk);
    in_valid = 1'b0;
    // Count rising edges after the accepting one
    edges = 0;
    while (out_valid !== 1'b1) begin
      if (edges > LATENCY_TIMEOUT) begin
        report_failure("timeout waiting for out_valid of the lone operation");
      end
      @(negedge cpuclk);
      edges++;
    end
    assert (edges == 3) else report_mismatch("out_valid latency", 3, edges);
    check_output();
    @(negedge cpuclk);
    assert (out_valid === 1'b0) else report_mismatch("out_valid", 1'b0, out_valid);
  endtask

  task automatic run_stream(input int first, input int last, input logic random_mode);
    int    idx;
    int    cycles;
    logic  offering;
    logic  bit_v;
    logic  hold_pending;
    vreg_t hold_data;
    id_t   hold_id;
    idx          = first;
    cycles       = 0;
    offering     = 1'b0;
    hold_pending = 1'b0;
    while (idx <= last || exp_data_q.size() > 0) begin
      @(negedge cpuclk);
      cycles++;
      if (cycles > STREAM_TIMEOUT) begin
        report_failure("timeout: operations did not all issue and retire");
      end
      // A result refused last cycle must still be there unchanged
      if (hold_pending) begin
        assert (out_valid === 1'b1) else report_mismatch("out_valid", 1'b1, out_valid);
        assert (out_data === hold_data) else report_mismatch("out_data", hold_data, out_data);
        assert (out_id === hold_id) else report_mismatch("out_id", hold_id, out_id);
      end
      bit_v = 1'b1;
      if (random_mode) begin
        take_bit(bit_v);
      end
      out_ready = bit_v;
      if (!offering && idx <= last) begin
        bit_v = 1'b1;
        if (random_mode) begin
          take_bit(bit_v);
        end
        if (bit_v) begin
          drive_entry(idx);
          offering = 1'b1;
        end
      end
      in_valid = offering;
      #1;
      if (!random_mode) begin
        assert (in_ready === 1'b1) else report_mismatch("in_ready", 1'b1, in_ready);
      end
      if (out_valid && !out_ready) begin
        assert (in_ready === 1'b0) else report_mismatch("in_ready", 1'b0, in_ready);
      end
      hold_pending = out_valid && !out_ready;
      hold_data    = out_data;
      hold_id      = out_id;
      if (out_valid && out_ready) begin
        check_output();
      end
      if (in_valid && in_ready) begin
        push_expected(idx);
        idx++;
        offering = 1'b0;
      end
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_func    = FN_ADD;
    in_gp_sel  = GROUP0_INDEX;
    in_id      = '0;
    in_srcv0   = '0;
    in_srcv1   = '0;
    out_ready  = 1'b0;
    lfsr_state = 16'd13;
    load_table();

    repeat (2) @(posedge cpuclk);
    @(negedge cpuclk);
    arst_n = 1'b1;

    check_reset_and_latency(0);
    run_stream(1, 11, 1'b0);
    run_stream(12, NUM_ENTRIES - 1, 1'b1);

    // Nothing left behind once the queue is empty
    @(negedge cpuclk);
    in_valid = 1'b0;
    #1;
    assert (out_valid === 1'b0) else report_mismatch("out_valid", 1'b0, out_valid);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* vpu_group.f */
source/vpu_pkg.sv
source/vpu_lane_alu.sv
source/vpu_issue_pipe.sv
source/vpu_group_unit.sv
source/vpu_retire.sv
source/vpu_group_top.sv
tb/vpu_group_tb.sv
